//--- feature_stencil_top.f
rtl/stencil_pkg.sv
rtl/features_padding.sv
rtl/line_window.sv
rtl/window_accum.sv
rtl/feature_stencil_top.sv
test/feature_stencil_sva.sv
test/feature_stencil_tb.sv

//--- rtl/feature_stencil_top.sv
// feature stencil top
// padding, 3x3 windowing and per-channel accumulation with spike output
`timescale 1ns/1ns
`default_nettype none

module feature_stencil_top #(
    parameter int                                img_width       = 5,
    parameter int                                img_high        = 4,
    parameter stencil_pkg::pixel_t               padding_value   = '0,
    parameter logic [stencil_pkg::sum_bits-1:0]  spike_threshold = 600
) (
    input  wire                   s_clk,
    input  wire                   s_rst,
    input  wire                   ready,
    output logic                  pix_req,
    input  wire                   pix_valid,
    input  stencil_pkg::pixel_t   pix_in,
    output logic                  feat_valid,
    output stencil_pkg::feature_t feat
);

    logic                 pad_valid;
    stencil_pkg::pixel_t  pad_pixel;
    logic                 win_valid;
    stencil_pkg::window_t win;

    features_padding #(
        .img_width    (img_width),
        .img_high     (img_high),
        .padding_value(padding_value)
    ) u_features_padding (
        .s_clk    (s_clk),
        .s_rst    (s_rst),
        .ready    (ready),
        .pix_req  (pix_req),
        .pix_valid(pix_valid),
        .pix_in   (pix_in),
        .pad_valid(pad_valid),
        .pad_pixel(pad_pixel)
    );

    line_window #(
        .img_width(img_width),
        .img_high (img_high)
    ) u_line_window (
        .s_clk    (s_clk),
        .s_rst    (s_rst),
        .pad_valid(pad_valid),
        .pad_pixel(pad_pixel),
        .win_valid(win_valid),
        .win      (win)
    );

    window_accum #(
        .spike_threshold(spike_threshold)
    ) u_window_accum (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .win_valid (win_valid),
        .win       (win),
        .feat_valid(feat_valid),
        .feat      (feat)
    );

endmodule

`default_nettype wire

//--- rtl/features_padding.sv
// feature padding
// walks the padded frame, emits padding on the border and requests
// interior pixels from the source
`timescale 1ns/1ns
`default_nettype none

module features_padding #(
    parameter int                  img_width     = 5,
    parameter int                  img_high      = 4,
    parameter stencil_pkg::pixel_t padding_value = '0
) (
    input  wire                 s_clk,
    input  wire                 s_rst,
    input  wire                 ready,
    output logic                pix_req,
    input  wire                 pix_valid,
    input  stencil_pkg::pixel_t pix_in,
    output logic                pad_valid,
    output stencil_pkg::pixel_t pad_pixel
);

    localparam int xw = $clog2(img_width + 2);
    localparam int yw = $clog2(img_high + 2);

    logic [xw-1:0]           pos_x;
    logic [yw-1:0]           pos_y;
    logic                    last_x;
    logic                    last_y;
    logic                    req_q;
    logic                    take;
    stencil_pkg::pad_region_e region;

    assign last_x = (pos_x == xw'(img_width + 1));
    assign last_y = (pos_y == yw'(img_high + 1));

    always_comb begin
        if (pos_y == '0)
            region = stencil_pkg::reg_top;
        else if (last_y)
            region = stencil_pkg::reg_bottom;
        else if (pos_x == '0 || last_x)
            region = stencil_pkg::reg_side;
        else
            region = stencil_pkg::reg_interior;
    end

    // request is held while the consumer stalls
    assign pix_req = req_q & ready;
    assign take    = pix_req & pix_valid;

    always_comb begin
        if (region == stencil_pkg::reg_interior) begin
            pad_valid = take;
            pad_pixel = pix_in;
        end else begin
            pad_valid = ready; // one border pixel per ready cycle
            pad_pixel = padding_value;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            req_q <= 1'b0;
        end else if (ready) begin
            req_q <= (region == stencil_pkg::reg_interior) && !take;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            pos_x <= '0;
            pos_y <= '0;
        end else if (pad_valid) begin
            if (last_x) begin
                pos_x <= '0;
                pos_y <= last_y ? '0 : pos_y + 1'b1; // wrap to next frame
            end else begin
                pos_x <= pos_x + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/line_window.sv
// line window
// two padded-row line buffers feeding a 3x3 shift window,
// one window per original pixel
`timescale 1ns/1ns
`default_nettype none

module line_window #(
    parameter int img_width = 5,
    parameter int img_high  = 4
) (
    input  wire                  s_clk,
    input  wire                  s_rst,
    input  wire                  pad_valid,
    input  stencil_pkg::pixel_t  pad_pixel,
    output logic                 win_valid,
    output stencil_pkg::window_t win
);

    localparam int xw = $clog2(img_width + 2);
    localparam int yw = $clog2(img_high + 2);

    stencil_pkg::pixel_t line0 [img_width+2]; // padded row y-1
    stencil_pkg::pixel_t line1 [img_width+2]; // padded row y-2

    logic [xw-1:0] col;
    logic [yw-1:0] row;
    logic          last_col;
    logic          last_row;

    assign last_col = (col == xw'(img_width + 1));
    assign last_row = (row == yw'(img_high + 1));

    // column shift through both line buffers into the window
    always_ff @(posedge s_clk) begin
        if (pad_valid) begin
            line0[col] <= pad_pixel;
            line1[col] <= line0[col];
            win.row0   <= {win.row0[1:0], line1[col]};
            win.row1   <= {win.row1[1:0], line0[col]};
            win.row2   <= {win.row2[1:0], pad_pixel};
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            col <= '0;
            row <= '0;
        end else if (pad_valid) begin
            if (last_col) begin
                col <= '0;
                row <= last_row ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // first two padded columns and rows never complete a window
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            win_valid <= 1'b0;
        else
            win_valid <= pad_valid && (col >= xw'(2)) && (row >= yw'(2));
    end

endmodule

`default_nettype wire

//--- rtl/stencil_pkg.sv
// stencil package
// pixel, window and result types shared by the feature front end
`default_nettype none

package stencil_pkg;

    localparam int quan_bits = 8;
    localparam int sum_bits  = quan_bits + 4; // nine values summed

    typedef struct packed {
        logic [quan_bits-1:0] ch0;
        logic [quan_bits-1:0] ch1;
        logic [quan_bits-1:0] ch2;
    } pixel_t;

    // index 0 of each row is the newest (rightmost) column
    typedef struct packed {
        pixel_t [2:0] row0; // top
        pixel_t [2:0] row1;
        pixel_t [2:0] row2; // bottom
    } window_t;

    typedef struct packed {
        logic [sum_bits-1:0] s0;
        logic [sum_bits-1:0] s1;
        logic [sum_bits-1:0] s2;
    } chan_sum_t;

    typedef struct packed {
        chan_sum_t  sums;
        logic [2:0] spikes; // bit i fires for channel i
    } feature_t;

    typedef enum logic [1:0] {
        reg_top,
        reg_bottom,
        reg_side,
        reg_interior
    } pad_region_e;

endpackage

`default_nettype wire

//--- rtl/window_accum.sv
// window accumulator
// two-stage per-channel adder tree over a 3x3 window plus the
// spike threshold compare
`timescale 1ns/1ns
`default_nettype none

module window_accum #(
    parameter logic [stencil_pkg::sum_bits-1:0] spike_threshold = 600
) (
    input  wire                   s_clk,
    input  wire                   s_rst,
    input  wire                   win_valid,
    input  stencil_pkg::window_t  win,
    output logic                  feat_valid,
    output stencil_pkg::feature_t feat
);

    stencil_pkg::chan_sum_t row_sum [3];
    stencil_pkg::chan_sum_t total;
    logic                   stage1_valid;

    function automatic stencil_pkg::chan_sum_t add_row(input stencil_pkg::pixel_t [2:0] p);
        stencil_pkg::chan_sum_t r;
        r.s0 = stencil_pkg::sum_bits'(p[0].ch0) + stencil_pkg::sum_bits'(p[1].ch0)
             + stencil_pkg::sum_bits'(p[2].ch0);
        r.s1 = stencil_pkg::sum_bits'(p[0].ch1) + stencil_pkg::sum_bits'(p[1].ch1)
             + stencil_pkg::sum_bits'(p[2].ch1);
        r.s2 = stencil_pkg::sum_bits'(p[0].ch2) + stencil_pkg::sum_bits'(p[1].ch2)
             + stencil_pkg::sum_bits'(p[2].ch2);
        return r;
    endfunction

    // stage one row sums
    always_ff @(posedge s_clk) begin
        row_sum[0] <= add_row(win.row0);
        row_sum[1] <= add_row(win.row1);
        row_sum[2] <= add_row(win.row2);
    end

    assign total.s0 = row_sum[0].s0 + row_sum[1].s0 + row_sum[2].s0;
    assign total.s1 = row_sum[0].s1 + row_sum[1].s1 + row_sum[2].s1;
    assign total.s2 = row_sum[0].s2 + row_sum[1].s2 + row_sum[2].s2;

    // stage two column total and threshold
    always_ff @(posedge s_clk) begin
        feat.sums      <= total;
        feat.spikes[0] <= total.s0 >= spike_threshold;
        feat.spikes[1] <= total.s1 >= spike_threshold;
        feat.spikes[2] <= total.s2 >= spike_threshold;
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            stage1_valid <= 1'b0;
            feat_valid   <= 1'b0;
        end else begin
            stage1_valid <= win_valid;
            feat_valid   <= stage1_valid;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds and runs the feature stencil testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module feature_stencil_tb \
    -f feature_stencil_top.f \
    -o feature_stencil_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/feature_stencil_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "testbench reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

//--- test/feature_stencil_sva.sv
// stencil assertions
// reset, pixel take and per-frame result count checks on the stencil top
`timescale 1ns/1ns
`default_nettype none

module feature_stencil_sva #(
    parameter int img_width = 5,
    parameter int img_high  = 4
) (
    input wire s_clk,
    input wire s_rst,
    input wire pix_req,
    input wire pix_valid,
    input wire pad_valid,
    input wire feat_valid
);

    localparam int frame_results = img_width * img_high;

    int   pad_x;
    int   pad_y;
    int   res_cnt;
    logic frame_wrap;
    logic in_interior;

    assign frame_wrap = pad_valid && (pad_x == img_width + 1) && (pad_y == img_high + 1);
    assign in_interior = (pad_x >= 1) && (pad_x <= img_width)
                      && (pad_y >= 1) && (pad_y <= img_high);

    // padded position and results seen in the current frame
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            pad_x   <= 0;
            pad_y   <= 0;
            res_cnt <= 0;
        end else begin
            if (pad_valid && pad_x == img_width + 1) begin
                pad_x <= 0;
                pad_y <= (pad_y == img_high + 1) ? 0 : pad_y + 1;
            end else if (pad_valid) begin
                pad_x <= pad_x + 1;
            end
            if (feat_valid)
                res_cnt <= (res_cnt == frame_results - 1) ? 0 : res_cnt + 1;
        end
    end

    reset_quiet: assert property (@(posedge s_clk) s_rst |-> !feat_valid)
        else $error("feat_valid high during reset");

    // every interior slot is filled by exactly one taken pixel
    take_fills_interior: assert property (@(posedge s_clk) disable iff (s_rst)
        (pix_req && pix_valid) == (pad_valid && in_interior))
        else $error("taken pixel and interior padded position disagree");

    frame_count: assert property (@(posedge s_clk) disable iff (s_rst)
        frame_wrap |-> ##3 (feat_valid && res_cnt == frame_results - 1))
        else $error("frame did not end with exactly one result per pixel");

endmodule

bind feature_stencil_top feature_stencil_sva #(
    .img_width(img_width),
    .img_high (img_high)
) u_feature_stencil_sva (
    .s_clk     (s_clk),
    .s_rst     (s_rst),
    .pix_req   (pix_req),
    .pix_valid (pix_valid),
    .pad_valid (pad_valid),
    .feat_valid(feat_valid)
);

`default_nettype wire

//--- test/feature_stencil_tb.sv
// feature stencil testbench
// runs the pattern frame twice through the stencil path with random
// source gaps and consumer stalls, checks sums and spikes of every result
`timescale 1ns/1ns
`default_nettype none

module feature_stencil_tb;

    localparam int img_width    = 5;
    localparam int img_high     = 4;
    localparam int frame_pixels = img_width * img_high;
    localparam int total_pixels = 2 * frame_pixels; // two frames back to back
    localparam int max_idle     = 2000;
    localparam int drain_cycles = 100;
    localparam logic [stencil_pkg::sum_bits-1:0] spike_threshold = 600;

    logic                  s_clk;
    logic                  s_rst;
    logic                  ready;
    logic                  pix_req;
    logic                  pix_valid;
    stencil_pkg::pixel_t   pix_in;
    logic                  feat_valid;
    stencil_pkg::feature_t feat;

    logic [35:0] patterns [2*frame_pixels]; // pixels first, then expected sums
    logic [15:0] lfsr_state;

    feature_stencil_top u_feature_stencil_top (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .ready     (ready),
        .pix_req   (pix_req),
        .pix_valid (pix_valid),
        .pix_in    (pix_in),
        .feat_valid(feat_valid),
        .feat      (feat)
    );

    initial begin
        s_clk = 1'b0;
        forever #20 s_clk = ~s_clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    task automatic draw_bit(output logic b);
        lfsr_state = lfsr_step(lfsr_state);
        b = lfsr_state[0];
    endtask

    // bit i fires when channel i reaches the threshold
    function automatic logic [2:0] spikes_from(input stencil_pkg::chan_sum_t s);
        return {s.s2 >= spike_threshold, s.s1 >= spike_threshold, s.s0 >= spike_threshold};
    endfunction

    // result r waits for its lower right neighbor
    function automatic int pixels_needed(input int r);
        int x;
        int y;
        int base;
        x    = (r % frame_pixels) % img_width;
        y    = (r % frame_pixels) / img_width;
        base = (r / frame_pixels) * frame_pixels;
        if (y == img_high - 1) // bottom row needs the whole frame
            return base + frame_pixels;
        return base + (y + 1) * img_width + ((x < img_width - 1) ? x + 2 : img_width);
    endfunction

    task automatic end_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_sums(input stencil_pkg::chan_sum_t got,
                              input stencil_pkg::chan_sum_t exp, input int idx);
        if (got !== exp) begin
            $display("[FAIL] feat.sums result %0d got 0x%h expected 0x%h", idx, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_spikes(input logic [2:0] got, input logic [2:0] exp, input int idx);
        if (got !== exp) begin
            $display("[FAIL] feat.spikes result %0d got 0x%h expected 0x%h", idx, got, exp);
            end_with_failure();
        end
    endtask

    task automatic drive_inputs(input int idx);
        logic b0;
        logic b1;
        logic b2;
        draw_bit(b0);
        draw_bit(b1);
        draw_bit(b2);
        ready     <= b0 | b1; // consumer drops about a quarter of cycles
        pix_valid <= (idx < total_pixels) ? b2 : 1'b0;
        pix_in    <= patterns[idx % frame_pixels][23:0];
    endtask

    initial begin
        stencil_pkg::chan_sum_t exp_sums;
        int in_idx;
        int out_idx;
        int idle;
        s_rst      = 1'b1;
        ready      = 1'b1;
        pix_valid  = 1'b0;
        pix_in     = '0;
        lfsr_state = 16'd69;
        in_idx     = 0;
        out_idx    = 0;
        idle       = 0;
        $readmemh("test/stencil_patterns.mem", patterns);

        for (int i = 0; i < 16; i++) begin
            @(posedge s_clk);
            if (pix_req !== 1'b0 || feat_valid !== 1'b0) begin
                $display("pix_req or feat_valid went high while reset was held");
                end_with_failure();
            end
        end
        s_rst <= 1'b0;

        while (out_idx < total_pixels) begin
            @(posedge s_clk);
            if (pix_req && pix_valid)
                in_idx++;
            if (feat_valid) begin
                if (in_idx < pixels_needed(out_idx)) begin
                    $display("result %0d came out before its window was complete", out_idx);
                    end_with_failure();
                end
                exp_sums = patterns[frame_pixels + out_idx % frame_pixels];
                check_sums(feat.sums, exp_sums, out_idx);
                check_spikes(feat.spikes, spikes_from(exp_sums), out_idx);
                out_idx++;
                idle = 0;
            end else if (idle == max_idle) begin
                $display("no result for %0d cycles after result %0d", max_idle, out_idx);
                end_with_failure();
            end else begin
                idle++;
            end
            drive_inputs(in_idx);
        end

        // nothing more may come out once the source is empty
        for (int i = 0; i < drain_cycles; i++) begin
            @(posedge s_clk);
            if (feat_valid) begin
                $display("an extra result came out after both frames were complete");
                end_with_failure();
            end
            drive_inputs(total_pixels);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/stencil_patterns.mem
// lines 0-19: input pixels in raster order, hex ch0 ch1 ch2 (8 bits each)
// lines 20-39: expected 3x3 sums with zero padding, hex s0 s1 s2 (12 bits each)
14A0FF
1E8C00
2878FF
326400
3C50FF
32A000
3C8CFF
467800
5064FF
5A5000
50A0FF
5A8C00
6478FF
6E6400
7850FF
6EA000
788CFF
827800
8C64FF
965000
0A02581FE
10E3482FD
14A2D02FD
1862582FD
1181681FE
14A3842FD
21C4EC4FB
2764383FC
2D03844FB
1FE21C2FD
1FE3842FD
32A4EC3FC
3844384FB
3DE3843FC
2B221C2FD
1902581FE
2763482FD
2B22D02FD
2EE2582FD
2081681FE
